/* rtl/pokeyPkg.sv */
package pokeyPkg;

   localparam int byteW = 8;
   localparam int addrW = 4;

   // Write addresses
   localparam logic [addrW-1:0] addrAudf1 = 4'h0;
   localparam logic [addrW-1:0] addrAudc1 = 4'h1;
   localparam logic [addrW-1:0] addrAudf2 = 4'h2;
   localparam logic [addrW-1:0] addrAudc2 = 4'h3;
   localparam logic [addrW-1:0] addrAudf3 = 4'h4;
   localparam logic [addrW-1:0] addrAudc3 = 4'h5;
   localparam logic [addrW-1:0] addrAudf4 = 4'h6;
   localparam logic [addrW-1:0] addrAudc4 = 4'h7;
   localparam logic [addrW-1:0] addrAudCtl = 4'h8;
   localparam logic [addrW-1:0] addrPotLatch = 4'hB;
   localparam logic [addrW-1:0] addrSkCtl = 4'hF;

   // Read addresses
   localparam logic [addrW-1:0] addrAllPot = 4'h8;
   localparam logic [addrW-1:0] addrRandom = 4'hA;

   // Base clock dividers at 100 MHz
   localparam int div15k = 3333;
   localparam int div15kW = 12;
   localparam int div64k = 781;
   localparam int div64kW = 10;
   localparam int div179m = 28;
   localparam int div179mW = 5;

   localparam int volW = 4;
   localparam int pwmW = 6;
   localparam int numVoices = 4;

endpackage

/* rtl/pokeyCtrlIf.sv */
`timescale 1ns/1ps

interface pokeyCtrlIf;

   logic [pokeyPkg::numVoices-1:0][pokeyPkg::byteW-1:0] audf;
   logic [pokeyPkg::numVoices-1:0][pokeyPkg::byteW-1:0] audc;
   logic [pokeyPkg::byteW-1:0] audCtl;
   // High while skCtl holds the chip in init
   logic initMode;

   modport regs (
      output audf, audc, audCtl, initMode
   );

   modport voices (
      input audf, audc, audCtl, initMode
   );

   modport mix (
      input audc, initMode
   );

endinterface

/* rtl/pokeyClockGen.sv */
`timescale 1ns/1ps

module pokeyClockGen #(
   parameter int cntW = 5,
   parameter int termCount = 28
) (
   input  logic clk,
   input  logic rst,
   input  logic clear,
   output logic wave,
   output logic pulse
);

   logic [cntW-1:0] cnt;

   assign pulse = (cnt == cntW'(termCount));

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         cnt <= '0;
         wave <= 1'b0;
      end
      else
      begin
         cnt <= pulse ? '0 : cnt + 1'b1;
         if (pulse)
            wave <= ~wave;
      end
   end

   // Reload always leaves a gap between pulses
   a_pulseSingle: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse);

endmodule

/* rtl/pokeyPoly.sv */
`timescale 1ns/1ps

module pokeyPoly (
   input  logic clk,
   input  logic rst,
   input  logic step,
   input  logic clear,
   input  logic reduce9,
   output logic rand4,
   output logic rand5,
   output logic rand17,
   output logic [pokeyPkg::byteW-1:0] rngByte
);

   logic [3:0] poly4;
   logic [4:0] poly5;
   logic [16:0] poly17;
   logic fb4;
   logic fb5;
   logic fb17;
   logic upperIn;

   assign fb4 = ~(poly4[3] ^ poly4[2]);
   assign fb5 = ~(poly5[4] ^ poly5[2]);
   assign fb17 = ~(poly17[16] ^ poly17[11]);

   // 9-bit mode skips the lower eight stages
   assign upperIn = reduce9 ? fb17 : poly17[7];

   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         poly4 <= '0;
         poly5 <= '0;
         poly17 <= '0;
      end
      else if (step)
      begin
         poly4 <= {poly4[2:0], fb4};
         poly5 <= {poly5[3:0], fb5};
         poly17 <= {poly17[15:8], upperIn, poly17[6:0], fb17};
      end
   end

   assign rand4 = poly4[3];
   assign rand5 = poly5[4];
   assign rand17 = poly17[16];
   assign rngByte = poly17[16:9];

endmodule

/* rtl/pokeyRegs.sv */
`timescale 1ns/1ps

module pokeyRegs (
   input  logic clk,
   input  logic rst,
   input  logic phi2,
   input  logic cs0Bar,
   input  logic readHighWriteLow,
   input  logic [pokeyPkg::addrW-1:0] addr,
   input  logic [pokeyPkg::byteW-1:0] din,
   input  logic [pokeyPkg::byteW-1:0] pins,
   input  logic [pokeyPkg::byteW-1:0] rngByte,
   output logic [pokeyPkg::byteW-1:0] dout,
   pokeyCtrlIf.regs ctrl
);

   logic [pokeyPkg::numVoices-1:0][pokeyPkg::byteW-1:0] audf;
   logic [pokeyPkg::numVoices-1:0][pokeyPkg::byteW-1:0] audc;
   logic [pokeyPkg::byteW-1:0] audCtl;
   logic [pokeyPkg::byteW-1:0] allPot;
   logic [1:0] skCtl;
   logic phi2Q;
   logic access;
   logic initMode;

   // First cycle of phi2 high with chip select
   assign access = phi2 && !phi2Q && !cs0Bar;
   assign initMode = (skCtl == 2'b00);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         phi2Q <= 1'b0;
         audf <= '0;
         audc <= '0;
         audCtl <= '0;
         allPot <= '0;
         skCtl <= '0;
         dout <= '0;
      end
      else
      begin
         phi2Q <= phi2;
         if (access && initMode)
         begin
            audf <= '0;
            audc <= '0;
            audCtl <= '0;
            allPot <= '0;
            dout <= '0;
            if (!readHighWriteLow && addr == pokeyPkg::addrSkCtl)
               skCtl <= din[1:0];
         end
         else if (access && readHighWriteLow)
         begin
            case (addr)
               pokeyPkg::addrAllPot: dout <= allPot;
               pokeyPkg::addrRandom: dout <= rngByte;
               default: dout <= '0;
            endcase
         end
         else if (access)
         begin
            case (addr)
               pokeyPkg::addrAudf1: audf[0] <= din;
               pokeyPkg::addrAudc1: audc[0] <= din;
               pokeyPkg::addrAudf2: audf[1] <= din;
               pokeyPkg::addrAudc2: audc[1] <= din;
               pokeyPkg::addrAudf3: audf[2] <= din;
               pokeyPkg::addrAudc3: audc[2] <= din;
               pokeyPkg::addrAudf4: audf[3] <= din;
               pokeyPkg::addrAudc4: audc[3] <= din;
               pokeyPkg::addrAudCtl: audCtl <= din;
               pokeyPkg::addrPotLatch: allPot <= pins;
               pokeyPkg::addrSkCtl: skCtl <= din[1:0];
               default: ;
            endcase
         end
      end
   end

   assign ctrl.audf = audf;
   assign ctrl.audc = audc;
   assign ctrl.audCtl = audCtl;
   assign ctrl.initMode = initMode;

   a_doutHold: assert property (@(posedge clk) disable iff (rst) !access |=> $stable(dout));

endmodule

/* rtl/pokeyChannel.sv */
`timescale 1ns/1ps

module pokeyChannel (
   input  logic clk,
   input  logic rst,
   input  logic clear,
   input  logic baseClk,
   input  logic [pokeyPkg::byteW-1:0] audf,
   input  logic [2:0] noiseSel,
   input  logic noiseA,
   input  logic noiseB,
   input  logic noise17,
   input  logic hpfClk,
   input  logic hpfOn,
   output logic rawWave,
   output logic divOut
);

   logic [pokeyPkg::byteW-1:0] cnt;
   logic baseQ;
   logic baseEdge;
   logic rollover;
   logic noise;
   logic noiseHold;
   logic divQ;
   logic gated;
   logic gatedQ;
   logic div2;
   logic hpfClkQ;
   logic hpfQ;

   // Both edges of the base wave are counted
   assign baseEdge = baseClk ^ baseQ;
   assign rollover = baseEdge && (cnt >= audf);

   always_comb
   begin
      casez (noiseSel)
         3'b000: noise = noiseB & noise17;
         3'b0?1: noise = noiseB;
         3'b010: noise = noiseA & noiseB;
         3'b100: noise = noise17;
         3'b110: noise = noiseA;
         default: noise = 1'b1;
      endcase
   end

   assign gated = divOut & noiseHold;
   assign rawWave = hpfOn ? (div2 ^ hpfQ) : div2;

   ////////////////////
   // Divider, noise gate, divide-by-2, filter flop
   always_ff @(posedge clk)
   begin
      if (rst || clear)
      begin
         cnt <= '0;
         baseQ <= 1'b0;
         divOut <= 1'b0;
         divQ <= 1'b0;
         noiseHold <= 1'b0;
         gatedQ <= 1'b0;
         div2 <= 1'b0;
         hpfClkQ <= 1'b0;
         hpfQ <= 1'b0;
      end
      else
      begin
         baseQ <= baseClk;
         divQ <= divOut;
         gatedQ <= gated;
         hpfClkQ <= hpfClk;
         if (baseEdge)
            cnt <= rollover ? '0 : cnt + 1'b1;
         if (rollover)
            divOut <= ~divOut;
         if (divOut && !divQ)
            noiseHold <= noise;
         if (gated && !gatedQ)
            div2 <= ~div2;
         if (hpfClk && !hpfClkQ)
            hpfQ <= div2;
      end
   end

endmodule

/* rtl/pokeyVoices.sv */
`timescale 1ns/1ps

module pokeyVoices (
   input  logic clk,
   input  logic rst,
   input  logic clk15k,
   input  logic clk64k,
   input  logic clk179m,
   input  logic rand4,
   input  logic rand5,
   input  logic rand17,
   pokeyCtrlIf.voices ctrl,
   output logic [pokeyPkg::numVoices-1:0] rawWave
);

   logic [pokeyPkg::numVoices-1:0] baseClks;
   logic [pokeyPkg::numVoices-1:0] hpfClks;
   logic [pokeyPkg::numVoices-1:0] hpfOn;
   logic [pokeyPkg::numVoices-1:0] divOut;
   logic baseSlow;

   always_comb
   begin
      baseSlow = ctrl.audCtl[0] ? clk15k : clk64k;
      baseClks[0] = ctrl.audCtl[6] ? clk179m : baseSlow;
      baseClks[1] = ctrl.audCtl[4] ? divOut[0] : baseSlow;
      baseClks[2] = ctrl.audCtl[5] ? clk179m : baseSlow;
      baseClks[3] = ctrl.audCtl[3] ? divOut[2] : baseSlow;
      // Voices 3 and 4 clock the filters of 1 and 2
      hpfClks = {2'b00, divOut[3], divOut[2]};
      hpfOn = {2'b00, ctrl.audCtl[1], ctrl.audCtl[2]};
   end

   for (genvar i = 0; i < pokeyPkg::numVoices; i++)
   begin : gVoice
      pokeyChannel u_channel (
         .clk(clk),
         .rst(rst),
         .clear(ctrl.initMode),
         .baseClk(baseClks[i]),
         .audf(ctrl.audf[i]),
         .noiseSel(ctrl.audc[i][7:5]),
         .noiseA(rand4),
         .noiseB(rand5),
         .noise17(rand17),
         .hpfClk(hpfClks[i]),
         .hpfOn(hpfOn[i]),
         .rawWave(rawWave[i]),
         .divOut(divOut[i])
      );
   end

endmodule

/* rtl/pokeyMixer.sv */
`timescale 1ns/1ps

module pokeyMixer (
   input  logic clk,
   input  logic rst,
   pokeyCtrlIf.mix ctrl,
   input  logic [pokeyPkg::numVoices-1:0] rawWave,
   output logic aud
);

   logic [pokeyPkg::pwmW-1:0] pwmCnt;
   logic [pokeyPkg::pwmW-1:0] sum;

   always_comb
   begin
      sum = '0;
      for (int i = 0; i < pokeyPkg::numVoices; i++)
      begin
         // Volume-only bit forces the level on
         if (rawWave[i] || ctrl.audc[i][pokeyPkg::volW])
            sum = sum + pokeyPkg::pwmW'(ctrl.audc[i][pokeyPkg::volW-1:0]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst || ctrl.initMode)
      begin
         pwmCnt <= '0;
         aud <= 1'b0;
      end
      else
      begin
         pwmCnt <= pwmCnt + 1'b1;
         aud <= (pwmCnt < sum);
      end
   end

   a_silent: assert property (@(posedge clk) disable iff (rst) (sum == '0) |=> !aud);

endmodule

/* rtl/pokey.sv */
`timescale 1ns/1ps

module pokey (
   input  logic clk,
   input  logic rst,
   input  logic [pokeyPkg::byteW-1:0] Din,
   output logic [pokeyPkg::byteW-1:0] Dout,
   input  logic [pokeyPkg::addrW-1:0] A,
   input  logic [pokeyPkg::byteW-1:0] P,
   input  logic phi2,
   input  logic readHighWriteLow,
   input  logic cs0Bar,
   output logic aud
);

   logic wave15k;
   logic wave64k;
   logic wave179m;
   logic pulse179m;
   logic rand4;
   logic rand5;
   logic rand17;
   logic [pokeyPkg::byteW-1:0] rngByte;
   logic [pokeyPkg::numVoices-1:0] rawWave;

   pokeyCtrlIf ctrl ();

   pokeyRegs u_regs (
      .clk(clk),
      .rst(rst),
      .phi2(phi2),
      .cs0Bar(cs0Bar),
      .readHighWriteLow(readHighWriteLow),
      .addr(A),
      .din(Din),
      .pins(P),
      .rngByte(rngByte),
      .dout(Dout),
      .ctrl(ctrl.regs)
   );

   ////////////////////
   // Base clocks
   pokeyClockGen #(.cntW(pokeyPkg::div15kW), .termCount(pokeyPkg::div15k)) u_clk15k (
      .clk(clk), .rst(rst), .clear(ctrl.initMode), .wave(wave15k), .pulse()
   );

   pokeyClockGen #(.cntW(pokeyPkg::div64kW), .termCount(pokeyPkg::div64k)) u_clk64k (
      .clk(clk), .rst(rst), .clear(ctrl.initMode), .wave(wave64k), .pulse()
   );

   pokeyClockGen #(.cntW(pokeyPkg::div179mW), .termCount(pokeyPkg::div179m)) u_clk179m (
      .clk(clk), .rst(rst), .clear(ctrl.initMode), .wave(wave179m), .pulse(pulse179m)
   );

   ////////////////////
   // Noise, voices, output
   pokeyPoly u_poly (
      .clk(clk),
      .rst(rst),
      .step(pulse179m),
      .clear(ctrl.initMode),
      .reduce9(ctrl.audCtl[7]),
      .rand4(rand4),
      .rand5(rand5),
      .rand17(rand17),
      .rngByte(rngByte)
   );

   pokeyVoices u_voices (
      .clk(clk), .rst(rst),
      .clk15k(wave15k), .clk64k(wave64k), .clk179m(wave179m),
      .rand4(rand4), .rand5(rand5), .rand17(rand17),
      .ctrl(ctrl.voices),
      .rawWave(rawWave)
   );

   pokeyMixer u_mixer (
      .clk(clk), .rst(rst), .ctrl(ctrl.mix), .rawWave(rawWave), .aud(aud)
   );

endmodule

/* testbench/tbPokeyChecks.svh */
int passCount = 0;
int errCount = 0;

task automatic checkByte(input int test, input string name,
   input logic [pokeyPkg::byteW-1:0] got, input logic [pokeyPkg::byteW-1:0] exp);
   if (got !== exp)
   begin
      $display("Error at %0t: test %0d, %s is %h, expected %h", $time, test, name, got, exp);
      errCount++;
   end
   else
   begin
      $display("Test %0d ok: %s is %h", test, name, got);
      passCount++;
   end
endtask

task automatic checkCount(input int test, input string name, input int got, input int exp,
   input int tol);
   if (got - exp > tol || exp - got > tol)
   begin
      $display("Error at %0t: test %0d, %s is %0d, expected %0d", $time, test, name, got, exp);
      errCount++;
   end
   else
   begin
      $display("Test %0d ok: %s is %0d", test, name, got);
      passCount++;
   end
endtask

// Second byte must be the first moved up by 0 to 7 places
task automatic checkShift(input int test, input logic [pokeyPkg::byteW-1:0] first,
   input logic [pokeyPkg::byteW-1:0] second);
   logic [pokeyPkg::byteW-1:0] mask;
   bit found;
   mask = '1;
   found = 1'b0;
   for (int k = 0; k < pokeyPkg::byteW; k++)
   begin
      if ((second >> k) == (first & (mask >> k)))
         found = 1'b1;
   end
   if (!found)
   begin
      $display("Error at %0t: test %0d, Dout %h is no shift of earlier Dout %h",
         $time, test, second, first);
      errCount++;
   end
   else
   begin
      $display("Test %0d ok: Dout %h follows %h", test, second, first);
      passCount++;
   end
endtask

/* testbench/tbPokey.sv */
`timescale 1ns/1ps

module tbPokey;

   typedef enum logic [2:0] {opWrite, opRead, opPwm, opHalf, opRand} opT;

   typedef struct {
      opT op;
      logic [pokeyPkg::addrW-1:0] addr;
      logic [pokeyPkg::byteW-1:0] data;
      int expVal;
   } entryT;

   localparam int toneN = 20;
   localparam int joinF1 = 1;
   localparam int joinF2 = 3;

   logic clk;
   logic rst;
   logic [pokeyPkg::byteW-1:0] Din;
   logic [pokeyPkg::byteW-1:0] Dout;
   logic [pokeyPkg::addrW-1:0] A;
   logic [pokeyPkg::byteW-1:0] P;
   logic phi2;
   logic readHighWriteLow;
   logic cs0Bar;
   logic aud;

   entryT stim[$];
   int seed = 32'h0411_8878;
   int cycles = 0;
   int limit = 0;
   int testIdx = 0;

   `include "tbPokeyChecks.svh"

   pokey u_pokey (
      .clk(clk),
      .rst(rst),
      .Din(Din),
      .Dout(Dout),
      .A(A),
      .P(P),
      .phi2(phi2),
      .readHighWriteLow(readHighWriteLow),
      .cs0Bar(cs0Bar),
      .aud(aud)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      wait (limit > 0);
      while (cycles < limit)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, test %0d did not finish", cycles, testIdx);
      $display("STATUS: FAIL");
      $finish;
   end

   function automatic void addEntry(opT op, logic [pokeyPkg::addrW-1:0] addr,
      logic [pokeyPkg::byteW-1:0] data, int expVal);
      entryT e;
      e = '{op, addr, data, expVal};
      stim.push_back(e);
   endfunction

   function automatic int entryCycles(entryT e);
      case (e.op)
         opPwm: return 70;
         opHalf: return 8 * e.expVal + 256;
         opRand: return 12;
         default: return 6;
      endcase
   endfunction

   ////////////////////
   // Bus and measurement
   task automatic busCycle(input logic rd, input logic [pokeyPkg::addrW-1:0] addr,
      input logic [pokeyPkg::byteW-1:0] data);
      @(posedge clk);
      phi2 <= 1'b1;
      cs0Bar <= 1'b0;
      readHighWriteLow <= rd;
      A <= addr;
      Din <= data;
      P <= data;
      // Access edge, then phi2 stays up one more cycle
      @(posedge clk);
      @(posedge clk);
      phi2 <= 1'b0;
      cs0Bar <= 1'b1;
      @(posedge clk);
      @(negedge clk);
   endtask

   task automatic countAudHigh(output int n);
      n = 0;
      repeat (2 ** pokeyPkg::pwmW)
      begin
         @(negedge clk);
         if (aud)
            n++;
      end
   endtask

   // First PWM pulse after a full PWM period of silence
   task automatic burstStart(output int t);
      int quiet;
      quiet = 0;
      @(negedge clk);
      while (!(aud && quiet >= 2 ** pokeyPkg::pwmW))
      begin
         quiet = aud ? 0 : quiet + 1;
         @(negedge clk);
      end
      t = cycles;
   endtask

   task automatic measureHalfPeriod(output int half);
      int t0;
      int t1;
      int t2;
      burstStart(t0);
      burstStart(t1);
      burstStart(t2);
      half = (t2 - t1) / 2;
   endtask

   task automatic readRandomPair(input int test);
      logic [pokeyPkg::byteW-1:0] first;
      busCycle(1'b1, pokeyPkg::addrRandom, '0);
      first = Dout;
      busCycle(1'b1, pokeyPkg::addrRandom, '0);
      checkShift(test, first, Dout);
   endtask

   initial
   begin
      logic [pokeyPkg::byteW-1:0] pin;
      logic [pokeyPkg::volW-1:0] vol;
      int r;
      int sum;
      int got;
      rst <= 1'b1;
      phi2 <= 1'b0;
      cs0Bar <= 1'b1;
      readHighWriteLow <= 1'b1;
      A <= '0;
      Din <= '0;
      P <= '0;

      // Reset state, then init mode clearing every access
      addEntry(opRead, pokeyPkg::addrAllPot, '0, 0);
      addEntry(opPwm, '0, '0, 0);
      r = $random(seed);
      pin = r[pokeyPkg::byteW-1:0];
      addEntry(opWrite, pokeyPkg::addrPotLatch, pin, 0);
      addEntry(opRead, pokeyPkg::addrAllPot, '0, 0);
      addEntry(opWrite, pokeyPkg::addrSkCtl, 8'h03, 0);
      r = $random(seed);
      pin = r[pokeyPkg::byteW-1:0];
      addEntry(opWrite, pokeyPkg::addrPotLatch, pin, 0);
      addEntry(opRead, pokeyPkg::addrAllPot, '0, int'(pin));

      // Volume-only levels on all voices
      sum = 0;
      for (int i = 0; i < pokeyPkg::numVoices; i++)
      begin
         r = $random(seed);
         vol = r[pokeyPkg::volW-1:0];
         sum += int'(vol);
         addEntry(opWrite, pokeyPkg::addrAudc1 + 4'(2 * i), {4'h1, vol}, 0);
      end
      addEntry(opPwm, '0, '0, sum);
      addEntry(opPwm, '0, '0, sum);

      // Pure tone on voice 1; the divide-by-2 doubles the divider half period
      for (int i = 1; i < pokeyPkg::numVoices; i++)
         addEntry(opWrite, pokeyPkg::addrAudc1 + 4'(2 * i), '0, 0);
      addEntry(opWrite, pokeyPkg::addrAudf1, 8'(toneN), 0);
      addEntry(opWrite, pokeyPkg::addrAudc1, 8'hAF, 0);
      addEntry(opWrite, pokeyPkg::addrAudCtl, 8'h40, 0);
      addEntry(opHalf, '0, '0, 2 * (toneN + 1) * (pokeyPkg::div179m + 1));

      // Voice 2 clocked by the divider of voice 1
      addEntry(opWrite, pokeyPkg::addrAudc1, '0, 0);
      addEntry(opWrite, pokeyPkg::addrAudf1, 8'(joinF1), 0);
      addEntry(opWrite, pokeyPkg::addrAudf2, 8'(joinF2), 0);
      addEntry(opWrite, pokeyPkg::addrAudc2, 8'hAF, 0);
      addEntry(opWrite, pokeyPkg::addrAudCtl, 8'h50, 0);
      addEntry(opHalf, '0, '0, 2 * (joinF2 + 1) * (joinF1 + 1) * (pokeyPkg::div179m + 1));
      addEntry(opRand, pokeyPkg::addrRandom, '0, 0);

      foreach (stim[k])
         limit += entryCycles(stim[k]);
      limit += 2000;

      repeat (4) @(posedge clk);
      rst <= 1'b0;

      for (int k = 0; k < stim.size(); k++)
      begin
         testIdx = k;
         case (stim[k].op)
            opWrite: busCycle(1'b0, stim[k].addr, stim[k].data);
            opRead:
            begin
               busCycle(1'b1, stim[k].addr, '0);
               checkByte(k, "Dout", Dout, stim[k].expVal[pokeyPkg::byteW-1:0]);
            end
            opPwm:
            begin
               countAudHigh(got);
               checkCount(k, "aud high cycles", got, stim[k].expVal, 0);
            end
            opHalf:
            begin
               measureHalfPeriod(got);
               checkCount(k, "aud half period", got, stim[k].expVal, 64);
            end
            default: readRandomPair(k);
         endcase
      end

      $display("Checks %0d, passed %0d, failed %0d", passCount + errCount, passCount, errCount);
      if (errCount == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* pokey.f */
+incdir+testbench
rtl/pokeyPkg.sv
rtl/pokeyCtrlIf.sv
rtl/pokeyClockGen.sv
rtl/pokeyPoly.sv
rtl/pokeyRegs.sv
rtl/pokeyChannel.sv
rtl/pokeyVoices.sv
rtl/pokeyMixer.sv
rtl/pokey.sv
testbench/tbPokey.sv

/* run.sh */
#!/bin/sh
# Build and run the pokey testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timescale 1ns/1ps --top-module tbPokey \
   -Mdir obj_dir -o tbPokey -f pokey.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tbPokey > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
   exit 1
fi
exit 0
